//--- design/misc_regs.sv
// Clock, ADC, LED and PHY control registers with sticky interrupt status
// Registered readback of time, status and interrupt words
`timescale 1ns/1ns

module misc_regs
   import u2_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       rst_n_i,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   input  logic       pps_int_i,
   input  logic       overrun0_i,
   input  logic       overrun1_i,
   input  logic       run0_i,
   input  logic       run1_i,
   input  logic       clk_status_i,
   input  logic [2:0] rb_addr_i,
   output set_data_t  rb_data_o,
   output logic [7:0] leds_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_b_o,
   output logic       adc_oe_b_o,
   output logic       phy_resetn_o
);

   logic [3:0] clk_ctrl;
   logic [3:0] adc_ctrl;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic       phy_reset;
   logic [2:0] irq;
   logic [2:0] irq_clr;
   logic [7:0] led_hw;

   function automatic logic wr_hit(input int offset);
      wr_hit = set_stb_i && set_addr_i == set_addr_t'(SR_MISC + offset);
   endfunction

   // Clear mask only acts in the cycle of its write
   assign irq_clr = wr_hit(5) ? set_data_i[2:0] : 3'b000;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         clk_ctrl  <= '0;
         adc_ctrl  <= '0;
         led_sw    <= '0;
         led_src   <= LED_SRC_AT_RESET;
         phy_reset <= 1'b0;
         irq       <= '0;
      end else begin
         if (wr_hit(0))
            clk_ctrl <= set_data_i[3:0];
         if (wr_hit(1))
            adc_ctrl <= set_data_i[3:0];
         if (wr_hit(2))
            led_sw <= set_data_i[7:0];
         if (wr_hit(3))
            led_src <= set_data_i[7:0];
         if (wr_hit(4))
            phy_reset <= set_data_i[0];
         // New events win over a clear in the same cycle
         irq <= (irq & ~irq_clr) | {pps_int_i, overrun1_i, overrun0_i};
      end
   end

   assign {clk_en_o, clk_sel_o} = clk_ctrl;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_ctrl;
   assign phy_resetn_o = !phy_reset;

   //////////////////////////////////////////////////
   // LEDs, per bit hardware or software source
   assign led_hw = {4'b0000, run0_i | run1_i, clk_status_i, irq[2], 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   always_ff @(posedge dsp_clk) begin
      case (rb_addr_i)
         RB_TIME_HI: rb_data_o <= vita_time_i[63:32];
         RB_TIME_LO: rb_data_o <= vita_time_i[31:0];
         RB_PPS_HI:  rb_data_o <= vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_data_o <= vita_time_pps_i[31:0];
         RB_COMPAT:  rb_data_o <= COMPAT_NUM;
         RB_IRQ:     rb_data_o <= {29'd0, irq};
         RB_STATUS:  rb_data_o <= {29'd0, run1_i, run0_i, clk_status_i};
         default:    rb_data_o <= '0;
      endcase
   end

endmodule

//--- design/rx_channel.sv
// One receive channel: decimated ADC capture framed into VITA-timed packets
// Each packet is a header word followed by spp sample words in its own FIFO
`timescale 1ns/1ns

module rx_channel
   import u2_pkg::*;
#(
   parameter int BASE = 0
) (
   input  logic      dsp_clk,
   input  logic      rst_n_i,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   input  vita_time_t vita_time_i,
   input  adc_t      adc_a_i,
   input  adc_t      adc_b_i,
   output rx_word_t  out_data_o,
   output logic      out_src_rdy_o,
   input  logic      out_dst_rdy_i,
   output logic      run_o,
   output logic      overrun_o
);

   localparam int SW = $clog2(MAX_SPP);

   logic                cmd_stb, decim_stb, spp_stb;
   logic [15:0]         pkts_left;
   logic [7:0]          decim_reg, decim_m1, dcnt;
   logic [SW-1:0]       spp_reg, spp_m1, scnt;
   logic [SW:0]         spp;
   logic [RX_FIFO_AW:0] fifo_free, need;
   logic                run, in_pkt, pend, pend_eop;
   logic                tick, fits, hdr_wr, cap, last_cap, fifo_wr;
   sample_t             sample, hold;
   rx_word_t            hdr_word, smp_word, fifo_data;

   assign cmd_stb   = set_stb_i && set_addr_i == set_addr_t'(BASE);
   assign decim_stb = set_stb_i && set_addr_i == set_addr_t'(BASE + 1);
   assign spp_stb   = set_stb_i && set_addr_i == set_addr_t'(BASE + 2);

   // Zero in either field selects the largest setting
   assign decim_m1 = decim_reg - 8'd1;
   assign spp      = (spp_reg == '0) ? (SW+1)'(MAX_SPP) : {1'b0, spp_reg};
   assign spp_m1   = SW'(spp - 1'b1);
   assign need     = (RX_FIFO_AW+1)'(spp) + 1'b1;

   assign sample = {{2{adc_a_i[13]}}, adc_a_i, {2{adc_b_i[13]}}, adc_b_i};

   //////////////////////////////////////////////////
   // Capture decisions
   assign tick     = run && dcnt == 8'd0;
   assign fits     = fifo_free >= need;
   // A still pending sample word holds off the next header by one edge
   assign hdr_wr   = tick && !in_pkt && !pend && fits;
   assign cap      = (tick && in_pkt) || hdr_wr;
   assign last_cap = in_pkt ? (scnt == spp_m1) : (spp_m1 == '0);

   assign hdr_word  = '{sop: 1'b1, eop: 1'b0, spare: 2'b00, data: vita_time_i[31:0]};
   assign smp_word  = '{sop: 1'b0, eop: pend_eop, spare: 2'b00, data: hold};
   assign fifo_wr   = hdr_wr || pend;
   assign fifo_data = hdr_wr ? hdr_word : smp_word;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         run       <= 1'b0;
         overrun_o <= 1'b0;
         pkts_left <= '0;
         decim_reg <= '0;
         spp_reg   <= '0;
         dcnt      <= '0;
         scnt      <= '0;
         in_pkt    <= 1'b0;
         pend      <= 1'b0;
      end else begin
         overrun_o <= 1'b0;
         pend      <= 1'b0;
         if (decim_stb)
            decim_reg <= set_data_i[7:0];
         if (spp_stb)
            spp_reg <= set_data_i[SW-1:0];
         if (cmd_stb) begin
            run       <= set_data_i[15:0] != 16'd0;
            pkts_left <= set_data_i[15:0];
            dcnt      <= '0;
            in_pkt    <= 1'b0;
         end else if (tick && !in_pkt && !pend && !fits) begin
            // No room for a whole packet
            overrun_o <= 1'b1;
            run       <= 1'b0;
         end else if (cap) begin
            dcnt     <= decim_m1;
            pend     <= 1'b1;
            pend_eop <= last_cap;
            scnt     <= in_pkt ? scnt + 1'b1 : SW'(1);
            in_pkt   <= !last_cap;
            if (last_cap) begin
               pkts_left <= pkts_left - 16'd1;
               if (pkts_left == 16'd1)
                  run <= 1'b0;
            end
         end else if (run && dcnt != 8'd0) begin
            dcnt <= dcnt - 8'd1;
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (cap)
         hold <= sample;
   end

   assign run_o = run;

   sample_fifo i_sample_fifo (
      .dsp_clk   (dsp_clk),
      .rst_n_i   (rst_n_i),
      .clear_i   (cmd_stb),
      .wr_i      (fifo_wr),
      .wr_data_i (fifo_data),
      .rd_data_o (out_data_o),
      .src_rdy_o (out_src_rdy_o),
      .dst_rdy_i (out_dst_rdy_i),
      .free_o    (fifo_free)
   );

endmodule

//--- design/sample_fifo.sv
// Circular buffer of stream words for one receive channel
// Reports free entries so the framer can reserve a whole packet
`timescale 1ns/1ns

module sample_fifo
   import u2_pkg::*;
(
   input  logic                  dsp_clk,
   input  logic                  rst_n_i,
   input  logic                  clear_i,
   input  logic                  wr_i,
   input  rx_word_t              wr_data_i,
   output rx_word_t              rd_data_o,
   output logic                  src_rdy_o,
   input  logic                  dst_rdy_i,
   output logic [RX_FIFO_AW:0]   free_o
);

   rx_word_t              mem [RX_FIFO_DEPTH];
   logic [RX_FIFO_AW-1:0] wr_ptr;
   logic [RX_FIFO_AW-1:0] rd_ptr;
   logic [RX_FIFO_AW:0]   count;
   logic                  rd;

   assign src_rdy_o = count != '0;
   assign rd        = src_rdy_o && dst_rdy_i;
   assign rd_data_o = mem[rd_ptr];
   assign free_o    = (RX_FIFO_AW+1)'(RX_FIFO_DEPTH) - count;

   always_ff @(posedge dsp_clk) begin
      if (wr_i)
         mem[wr_ptr] <= wr_data_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= rd_ptr + 1'b1;
         if (wr_i && !rd)
            count <= count + 1'b1;
         else if (rd && !wr_i)
            count <= count - 1'b1;
      end
   end

endmodule

//--- design/stream_arbiter.sv
// Round-robin merge of the two channel streams onto one output
// A grant is held from the first offered word through the eop transfer
`timescale 1ns/1ns

module stream_arbiter
   import u2_pkg::*;
(
   input  logic     dsp_clk,
   input  logic     rst_n_i,
   input  rx_word_t in0_data_i,
   input  logic     in0_src_rdy_i,
   output logic     in0_dst_rdy_o,
   input  rx_word_t in1_data_i,
   input  logic     in1_src_rdy_i,
   output logic     in1_dst_rdy_o,
   output rx_word_t stream_data_o,
   output logic     stream_chan_o,
   output logic     stream_src_rdy_o,
   input  logic     stream_dst_rdy_i
);

   logic lock;
   logic owner;
   logic last;
   logic sel;
   logic xfer;

   always_comb begin
      if (lock)
         sel = owner;
      else if (in0_src_rdy_i && in1_src_rdy_i)
         sel = !last;
      else
         sel = in1_src_rdy_i;
   end

   assign stream_data_o    = sel ? in1_data_i : in0_data_i;
   assign stream_src_rdy_o = sel ? in1_src_rdy_i : in0_src_rdy_i;
   assign stream_chan_o    = sel;
   assign in0_dst_rdy_o    = stream_dst_rdy_i && !sel;
   assign in1_dst_rdy_o    = stream_dst_rdy_i && sel;
   assign xfer             = stream_src_rdy_o && stream_dst_rdy_i;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         lock  <= 1'b0;
         owner <= 1'b0;
         // Channel 0 goes first
         last  <= 1'b1;
      end else if (lock) begin
         if (xfer && stream_data_o.eop)
            lock <= 1'b0;
      end else if (stream_src_rdy_o) begin
         // Grab the grant as soon as a word is offered so it holds steady
         lock  <= !(xfer && stream_data_o.eop);
         owner <= sel;
         last  <= sel;
      end
   end

endmodule

//--- design/time_keeper.sv
// 64-bit VITA time counter, loaded over the settings bus
// Captures the running time on each rising PPS edge
`timescale 1ns/1ns

module time_keeper
   import u2_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       rst_n_i,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o
);

   set_data_t hi_pending;
   logic      pps_d;
   logic      pps_edge;

   assign pps_edge = pps_i && !pps_d;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         vita_time_o <= '0;
         hi_pending  <= '0;
         pps_d       <= 1'b1;
         pps_int_o   <= 1'b0;
      end else begin
         pps_d     <= pps_i;
         pps_int_o <= pps_edge;
         if (set_stb_i && set_addr_i == set_addr_t'(SR_TIME64))
            hi_pending <= set_data_i;
         // Low word write commits the full 64-bit value
         if (set_stb_i && set_addr_i == set_addr_t'(SR_TIME64 + 1))
            vita_time_o <= {hi_pending, set_data_i};
         else
            vita_time_o <= vita_time_o + 64'd1;
      end
   end

   // Time as seen at the PPS edge, before this edge's increment
   always_ff @(posedge dsp_clk) begin
      if (pps_edge)
         vita_time_pps_o <= vita_time_o;
   end

endmodule

//--- design/u2_core.sv
// Receive and timing core top level
// Time keeper, two receive channels, stream merge and misc registers
`timescale 1ns/1ns

module u2_core
   import u2_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       rst_n_i,
   // Settings bus
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   input  adc_t       adc_a_i,
   input  adc_t       adc_b_i,
   input  logic       clk_status_i,
   input  logic [2:0] rb_addr_i,
   output set_data_t  rb_data_o,
   // Merged sample stream
   output rx_word_t   stream_data_o,
   output logic       stream_chan_o,
   output logic       stream_src_rdy_o,
   input  logic       stream_dst_rdy_i,
   output logic [7:0] leds_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_b_o,
   output logic       adc_oe_b_o,
   output logic       phy_resetn_o
);

   vita_time_t vita_time, vita_time_pps;
   logic       pps_int;
   rx_word_t   rx0_data, rx1_data;
   logic       rx0_src_rdy, rx0_dst_rdy, rx1_src_rdy, rx1_dst_rdy;
   logic       run0, run1, overrun0, overrun1;

   time_keeper i_time_keeper (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int)
   );

   //////////////////////////////////////////////////
   // Receive channels
   rx_channel #(.BASE(SR_RX_CTRL0)) i_rx_channel0 (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .vita_time_i(vita_time), .adc_a_i(adc_a_i), .adc_b_i(adc_b_i),
      .out_data_o(rx0_data), .out_src_rdy_o(rx0_src_rdy), .out_dst_rdy_i(rx0_dst_rdy),
      .run_o(run0), .overrun_o(overrun0)
   );

   rx_channel #(.BASE(SR_RX_CTRL1)) i_rx_channel1 (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .vita_time_i(vita_time), .adc_a_i(adc_a_i), .adc_b_i(adc_b_i),
      .out_data_o(rx1_data), .out_src_rdy_o(rx1_src_rdy), .out_dst_rdy_i(rx1_dst_rdy),
      .run_o(run1), .overrun_o(overrun1)
   );

   stream_arbiter i_stream_arbiter (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .in0_data_i(rx0_data), .in0_src_rdy_i(rx0_src_rdy), .in0_dst_rdy_o(rx0_dst_rdy),
      .in1_data_i(rx1_data), .in1_src_rdy_i(rx1_src_rdy), .in1_dst_rdy_o(rx1_dst_rdy),
      .stream_data_o(stream_data_o), .stream_chan_o(stream_chan_o),
      .stream_src_rdy_o(stream_src_rdy_o), .stream_dst_rdy_i(stream_dst_rdy_i)
   );

   //////////////////////////////////////////////////
   // Control registers and readback
   misc_regs i_misc_regs (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps), .pps_int_i(pps_int),
      .overrun0_i(overrun0), .overrun1_i(overrun1), .run0_i(run0), .run1_i(run1),
      .clk_status_i(clk_status_i), .rb_addr_i(rb_addr_i), .rb_data_o(rb_data_o),
      .leds_o(leds_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .adc_on_a_o(adc_on_a_o), .adc_oe_a_o(adc_oe_a_o),
      .adc_on_b_o(adc_on_b_o), .adc_oe_b_o(adc_oe_b_o),
      .phy_resetn_o(phy_resetn_o)
   );

endmodule

//--- design/u2_pkg.sv
// Shared definitions for the receive and timing core
// Register map, stream word layout and buffer sizes

package u2_pkg;

   //////////////////////////////////////////////////
   // Settings register bases
   localparam int SR_MISC     = 0;
   localparam int SR_RX_CTRL1 = 32;
   localparam int SR_RX_CTRL0 = 176;
   localparam int SR_TIME64   = 192;

   // Sample FIFO geometry
   localparam int RX_FIFO_DEPTH = 32;
   localparam int RX_FIFO_AW    = 5;
   localparam int MAX_SPP       = 16;

   localparam logic [7:0] LED_SRC_AT_RESET = 8'h1e;
   localparam logic [31:0] COMPAT_NUM      = 32'd5;

   //////////////////////////////////////////////////
   // Readback word addresses
   localparam logic [2:0] RB_TIME_HI = 3'd0;
   localparam logic [2:0] RB_TIME_LO = 3'd1;
   localparam logic [2:0] RB_PPS_HI  = 3'd2;
   localparam logic [2:0] RB_PPS_LO  = 3'd3;
   localparam logic [2:0] RB_COMPAT  = 3'd4;
   localparam logic [2:0] RB_IRQ     = 3'd5;
   localparam logic [2:0] RB_STATUS  = 3'd6;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [13:0] adc_t;
   // I in the upper half, Q in the lower half
   typedef logic [31:0] sample_t;

   // Flags on top of the 32 data bits
   typedef struct packed {
      logic        sop;
      logic        eop;
      logic [1:0]  spare;
      logic [31:0] data;
   } rx_word_t;

endpackage

//--- list.f
design/u2_pkg.sv
design/time_keeper.sv
design/sample_fifo.sv
design/rx_channel.sv
design/stream_arbiter.sv
design/misc_regs.sv
design/u2_core.sv
sim/u2_core_checker.sv
sim/tb_u2_core.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass is decided from the log
rm -f run.log
verilator --binary --timing --assert --top-module tb_u2_core -f list.f -o tb_u2_core \
   && ./obj_dir/tb_u2_core > run.log 2>&1 || { cat run.log 2>/dev/null; exit 1; }
cat run.log
grep -qx "Testbench passed" run.log || exit 1

//--- sim/stimulus_input.txt
# Columns (hex): W addr data | A adc_a adc_b | N cycles | R rb_addr expected | T time check
# P pps pulse | U pps time check | S chan pkts spp decim sample | D consumer | E idle | L leds ctrl
L 04 100
R 4 5
W c0 12345678
W c1 9abcdef0
N 14
T
P
N 8
U
R 5 4
W 5 4
R 5 0
A 2abc 0567
W b1 4
W b2 5
W b0 3
S 0 3 5 4 eabc0567
W 21 5
W 22 4
W b0 3
W 20 3
S 0 3 5 4 eabc0567
S 1 3 4 5 eabc0567
D 0
W b2 0
W b0 64
N 100
R 5 1
R 6 1
D 1
S 0 1 10 4 eabc0567
E
W 2 a5
W 3 0f
W 0 9
W 1 6
W 4 1
L a4 96

//--- sim/tb_u2_core.sv
// Testbench for the receive and timing core
// Runs the command rows of the stimulus file and checks stream, readback and control outputs
`timescale 1ns/1ns

module tb_u2_core
   import u2_pkg::*;
;

   typedef struct packed {
      logic [7:0]  op;
      logic [31:0] a0;
      logic [31:0] a1;
      logic [31:0] a2;
      logic [31:0] a3;
      logic [31:0] a4;
   } cmd_t;

   logic       dsp_clk;
   logic       rst_n_i;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic       pps_i;
   adc_t       adc_a_i;
   adc_t       adc_b_i;
   logic       clk_status_i;
   logic [2:0] rb_addr_i;
   set_data_t  rb_data_o;
   rx_word_t   stream_data_o;
   logic       stream_chan_o;
   logic       stream_src_rdy_o;
   logic       stream_dst_rdy_i;
   logic [7:0] leds_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic       adc_on_a_o;
   logic       adc_oe_a_o;
   logic       adc_on_b_o;
   logic       adc_oe_b_o;
   logic       phy_resetn_o;

   cmd_t       cmds[$];
   rx_word_t   q0[$];
   rx_word_t   q1[$];
   int         mismatches = 0;
   int         other_errors = 0;
   integer     seed = 32'h17b7_d9f2;
   int         rnd;
   logic       rand_mode = 1'b1;
   longint     cyc = 0;
   longint     budget = 0;
   logic       budget_ready = 1'b0;
   set_data_t  pend_hi = '0;
   vita_time_t load_val = '0;
   longint     load_edge = 0;
   longint     cmd_edge0 = 0;
   longint     cmd_edge1 = 0;
   vita_time_t pps_exp = '0;
   logic       in_pkt = 1'b0;
   logic       cur_chan = 1'b0;
   logic       offered = 1'b0;
   logic       last_chan = 1'b1;

   u2_core i_u2_core (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #20 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk)
      cyc <= cyc + 1;

   // Consumer side of the output stream
   always @(negedge dsp_clk) begin
      rnd = $random(seed);
      stream_dst_rdy_i = rand_mode ? rnd[0] : 1'b0;
   end

   //////////////////////////////////////////////////
   // Stream monitor, one queue per channel
   always @(posedge dsp_clk) begin
      // First offer of a packet picks the channel not served last
      if (rst_n_i && stream_src_rdy_o && !in_pkt && !offered) begin
         if (i_u2_core.rx0_src_rdy && i_u2_core.rx1_src_rdy && stream_chan_o == last_chan) begin
            $display("Channel %0d served twice in a row while both channels were pending",
                     stream_chan_o);
            other_errors++;
         end
         offered = 1'b1;
         last_chan = stream_chan_o;
      end
      if (rst_n_i && stream_src_rdy_o && stream_dst_rdy_i) begin
         if (!in_pkt && !stream_data_o.sop) begin
            $display("Stream word without a header on channel %0d", stream_chan_o);
            other_errors++;
         end
         if (in_pkt && stream_chan_o != cur_chan) begin
            $display("Packet on channel %0d interrupted by the other channel", cur_chan);
            other_errors++;
         end
         if (stream_data_o.sop) begin
            in_pkt = 1'b1;
            cur_chan = stream_chan_o;
         end
         if (stream_data_o.eop) begin
            in_pkt = 1'b0;
            offered = 1'b0;
         end
         if (stream_chan_o)
            q1.push_back(stream_data_o);
         else
            q0.push_back(stream_data_o);
      end
   end

   task automatic check_word(input string name, input rx_word_t got, input rx_word_t exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_time(input string name, input vita_time_t got, input vita_time_t exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_data(input string name, input set_data_t got, input set_data_t exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         mismatches++;
      end
   endtask

   // Time after posedge number e, counting from the last load
   function automatic vita_time_t exp_time(input longint e);
      return load_val + vita_time_t'(e - load_edge);
   endfunction

   task automatic set_write(input set_addr_t addr, input set_data_t data);
      @(negedge dsp_clk);
      set_stb_i = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      if (addr == set_addr_t'(SR_TIME64))
         pend_hi = data;
      if (addr == set_addr_t'(SR_TIME64 + 1)) begin
         load_val = {pend_hi, data};
         load_edge = cyc + 1;
      end
      if (addr == set_addr_t'(SR_RX_CTRL0))
         cmd_edge0 = cyc + 1;
      if (addr == set_addr_t'(SR_RX_CTRL1))
         cmd_edge1 = cyc + 1;
      @(negedge dsp_clk);
      set_stb_i = 1'b0;
   endtask

   // Readback registers the word at the next edge
   task automatic read_rb(input logic [2:0] addr, output set_data_t data, output longint e);
      @(negedge dsp_clk);
      rb_addr_i = addr;
      e = cyc;
      @(negedge dsp_clk);
      data = rb_data_o;
   endtask

   task automatic read_time(input logic [2:0] lo_addr, output vita_time_t t,
                            output longint e_lo, output longint e_hi);
      set_data_t lo;
      set_data_t hi;
      read_rb(lo_addr, lo, e_lo);
      read_rb(lo_addr - 3'd1, hi, e_hi);
      t = {hi, lo};
   endtask

   task automatic check_stream(input logic chan, input int pkts, input int spp,
                               input int decim, input set_data_t sample);
      rx_word_t w;
      rx_word_t exp;
      vita_time_t t0;
      int need;
      need = pkts * (spp + 1);
      // Time in the cycle before the first capture edge
      t0 = exp_time(chan ? cmd_edge1 : cmd_edge0);
      while ((chan ? q1.size() : q0.size()) < need)
         @(negedge dsp_clk);
      for (int p = 0; p < pkts; p++) begin
         w = chan ? q1.pop_front() : q0.pop_front();
         // Headers advance by one packet of decimated samples
         exp = '{sop: 1'b1, eop: 1'b0, spare: 2'b00,
                 data: t0[31:0] + set_data_t'(p * spp * decim)};
         check_word("stream header", w, exp);
         for (int i = 0; i < spp; i++) begin
            w = chan ? q1.pop_front() : q0.pop_front();
            exp = '{sop: 1'b0, eop: (i == spp - 1), spare: 2'b00, data: sample};
            check_word("stream sample", w, exp);
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Watchdog
   initial begin
      wait (budget_ready);
      #(budget * 40);
      $display("Watchdog expired after %0d cycles without finishing", budget);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      int fd;
      string line;
      cmd_t c;
      set_data_t d;
      vita_time_t t;
      vita_time_t t_exp;
      vita_time_t t_hi;
      longint e0;
      longint e1;
      rst_n_i = 1'b0;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      pps_i = 1'b0;
      adc_a_i = '0;
      adc_b_i = '0;
      clk_status_i = 1'b1;
      rb_addr_i = '0;
      stream_dst_rdy_i = 1'b0;
      fd = $fopen("sim/stimulus_input.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file");
         $display("Testbench failed");
         $finish;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               c = '0;
               void'($sscanf(line, "%c %h %h %h %h %h", c.op, c.a0, c.a1, c.a2, c.a3, c.a4));
               cmds.push_back(c);
               if (c.op == "N")
                  budget += longint'(c.a0);
               else if (c.op == "S")
                  budget += longint'(c.a1) * longint'(c.a2 + 1) * longint'(c.a3) + 40;
               else
                  budget += 8;
            end
         end
         $fclose(fd);
         budget = budget * 4 + 50;
         budget_ready = 1'b1;
         repeat (3) @(posedge dsp_clk);
         @(negedge dsp_clk);
         rst_n_i = 1'b1;
         foreach (cmds[k]) begin
            c = cmds[k];
            case (c.op)
               "W": set_write(c.a0[7:0], c.a1);
               "A": begin
                  @(negedge dsp_clk);
                  adc_a_i = c.a0[13:0];
                  adc_b_i = c.a1[13:0];
               end
               "N": repeat (int'(c.a0)) @(negedge dsp_clk);
               "R": begin
                  read_rb(c.a0[2:0], d, e0);
                  check_data("rb_data_o", d, c.a1);
               end
               "T": begin
                  read_time(RB_TIME_LO, t, e0, e1);
                  t_exp = exp_time(e0);
                  t_hi = exp_time(e1);
                  check_time("vita_time", t, {t_hi[63:32], t_exp[31:0]});
               end
               "P": begin
                  @(negedge dsp_clk);
                  pps_i = 1'b1;
                  pps_exp = exp_time(cyc);
                  repeat (2) @(negedge dsp_clk);
                  pps_i = 1'b0;
               end
               "U": begin
                  read_time(RB_PPS_LO, t, e0, e1);
                  check_time("vita_time_pps", t, pps_exp);
               end
               "S": check_stream(c.a0[0], int'(c.a1), int'(c.a2), int'(c.a3), c.a4);
               "D": rand_mode = c.a0[0];
               "E": begin
                  repeat (40) @(negedge dsp_clk);
                  if (q0.size() != 0 || q1.size() != 0) begin
                     $display("Unexpected stream words left: %0d on ch0, %0d on ch1",
                              q0.size(), q1.size());
                     other_errors++;
                  end
               end
               "L": begin
                  @(negedge dsp_clk);
                  check_data("leds_o", {24'd0, leds_o}, c.a0);
                  check_data("control outputs", {23'd0, phy_resetn_o, clk_en_o, clk_sel_o,
                             adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}, c.a1);
               end
               default: begin
                  $display("Unknown command in the stimulus file");
                  other_errors++;
               end
            endcase
         end
         $display("Checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
         if (mismatches == 0 && other_errors == 0) begin
            $display("Testbench passed");
         end else begin
            $display("Testbench failed");
         end
         $finish;
      end
   end

endmodule

//--- sim/u2_core_checker.sv
// Assertions on the merged output stream handshake
`timescale 1ns/1ns

module u2_core_checker
   import u2_pkg::*;
(
   input logic     dsp_clk,
   input logic     rst_n_i,
   input rx_word_t stream_data_o,
   input logic     stream_chan_o,
   input logic     stream_src_rdy_o,
   input logic     stream_dst_rdy_i
);

   // Offered word holds until it is taken
   hold_until_xfer: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      stream_src_rdy_o && !stream_dst_rdy_i |=>
         stream_src_rdy_o && $stable(stream_data_o) && $stable(stream_chan_o))
      else $error("Stream word or channel changed before its transfer");

   idle_after_reset: assert property (@(posedge dsp_clk) !rst_n_i |=> !stream_src_rdy_o)
      else $error("Stream source ready high right after reset");

endmodule

bind u2_core u2_core_checker i_u2_core_checker (.*);
